//--- logic/nn_pkg.sv
`default_nettype none

package nn_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// float format
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int EXP_W    = 8;
	localparam int MANT_W   = 23;
	localparam int EXP_BIAS = 127;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exponent;   // biased, 0 reads as zero
		logic [MANT_W-1:0] mantissa;   // hidden one not stored
	} float_t;

	// largest finite magnitude, used for saturation
	localparam float_t FLOAT_MAX_MAG = '{
		sign:     1'b0,
		exponent: 8'd254,
		mantissa: '1
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// layer shape
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int N_INPUTS = 8;
	localparam int N_NODES  = 3;

	typedef float_t act_vec_t [N_INPUTS];

	// fixed weights, all magnitudes below 1.0
	localparam float_t node_weights [N_NODES][N_INPUTS] = '{
		'{  // node 0
			32'hBD3E_2C61,
			32'h3EBB_4EA3,
			32'hBE23_A805,
			32'hBE4B_CEBD,
			32'h3D3A_95C8,
			32'hBDEB_BBE2,
			32'h3F09_2C0B,
			32'h3E52_36B7
		},
		'{  // node 1
			32'h3E24_97D1,
			32'hBA3C_F5D8,
			32'hBF4B_F38E,
			32'hBD55_796A,
			32'h3EBD_147F,
			32'h3F06_7C19,
			32'hBE0C_A5BB,
			32'h3E9A_51C4
		},
		'{  // node 2
			32'hBF21_D7E3,
			32'h3D8F_4A26,
			32'hBE7C_3190,
			32'h3F3B_62A8,
			32'hBD1E_07F5,
			32'h3E05_C9D2,
			32'hBEB4_E817,
			32'h3F5A_0C3E
		}
	};

	// occupancy of a pipeline register
	typedef enum logic {
		slot_empty,
		slot_full
	} slot_state_t;

endpackage

`default_nettype wire

//--- logic/node_if.sv
`default_nettype none

// activations out to one neuron, its result back
interface node_if import nn_pkg::*; ();

	act_vec_t act;
	logic     act_valid;   // input slot holds a vector
	float_t   sum;         // after relu
	logic     sum_neg;     // raw sum was negative

	modport layer (
		output act,
		output act_valid,
		input  sum,
		input  sum_neg
	);

	modport node (
		input  act,
		input  act_valid,
		output sum,
		output sum_neg
	);

endinterface

`default_nettype wire

//--- logic/float_mult.sv
`default_nettype none

module float_mult import nn_pkg::*; (
	input  float_t x,
	input  float_t y,
	output float_t z
);

	logic              zero_in;
	logic              sign;
	logic [23:0]       mant_x;
	logic [23:0]       mant_y;
	logic [47:0]       prod;
	logic              carry;
	logic [22:0]       frac;
	logic signed [9:0] exp_adj;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mantissa product
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign zero_in = (x.exponent == 8'd0) || (y.exponent == 8'd0);
	assign sign    = x.sign ^ y.sign;

	assign mant_x = {1'b1, x.mantissa};
	assign mant_y = {1'b1, y.mantissa};
	assign prod   = mant_x * mant_y;   // in [1.0, 4.0)

	// product at or above 2.0 takes one right shift
	assign carry = prod[47];
	assign frac  = carry ? prod[46:24] : prod[45:23];   // truncated

	// ten bits signed, room for both under- and overflow
	assign exp_adj = 10'(x.exponent) + 10'(y.exponent) + 10'(carry)
		- 10'(EXP_BIAS);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		z = '0;
		if (zero_in)
		begin
			z = '0;
		end
		else if (exp_adj <= 10'sd0)
		begin
			z = '0;   // underflow flushes
		end
		else if (exp_adj > 10'(FLOAT_MAX_MAG.exponent))
		begin
			z.sign     = sign;
			z.exponent = FLOAT_MAX_MAG.exponent;
			z.mantissa = FLOAT_MAX_MAG.mantissa;
		end
		else
		begin
			z.sign     = sign;
			z.exponent = exp_adj[7:0];
			z.mantissa = frac;
		end
	end

endmodule

`default_nettype wire

//--- logic/float_adder.sv
`default_nettype none

module float_adder import nn_pkg::*; (
	input  float_t a,
	input  float_t b,
	output float_t sum
);

	float_t            op_a;
	float_t            op_b;
	float_t            hi_op;
	float_t            lo_op;
	logic [23:0]       hi_mant;
	logic [23:0]       lo_mant;
	logic [7:0]        exp_diff;
	logic [23:0]       lo_aligned;
	logic              do_sub;
	logic [24:0]       raw;
	logic [4:0]        lead_zeros;
	logic [23:0]       norm_mant;
	logic signed [9:0] norm_exp;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand ordering
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// zero exponent means zero, whatever the mantissa holds
	assign op_a = (a.exponent == 8'd0) ? '0 : a;
	assign op_b = (b.exponent == 8'd0) ? '0 : b;

	// larger magnitude first, sign ignored here
	always_comb
	begin
		if ({op_a.exponent, op_a.mantissa} >= {op_b.exponent, op_b.mantissa})
		begin
			hi_op = op_a;
			lo_op = op_b;
		end
		else
		begin
			hi_op = op_b;
			lo_op = op_a;
		end
	end

	// hidden one only for nonzero operands
	assign hi_mant = {hi_op.exponent != 8'd0, hi_op.mantissa};
	assign lo_mant = {lo_op.exponent != 8'd0, lo_op.mantissa};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// align and add
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign exp_diff   = hi_op.exponent - lo_op.exponent;
	assign lo_aligned = lo_mant >> exp_diff;   // bits shifted out are lost
	assign do_sub     = hi_op.sign ^ lo_op.sign;

	// hi is the larger, so the difference never goes negative
	assign raw = do_sub ? ({1'b0, hi_mant} - {1'b0, lo_aligned})
		: ({1'b0, hi_mant} + {1'b0, lo_aligned});

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// normalize
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// leading zeros of raw[23:0], highest set bit wins
	always_comb
	begin
		lead_zeros = 5'd0;
		for (int i = 0; i < 24; i++)
		begin
			if (raw[i])
				lead_zeros = 5'(23 - i);
		end
	end

	assign norm_mant = raw[23:0] << lead_zeros;
	assign norm_exp  = 10'(hi_op.exponent) - 10'(lead_zeros);

	always_comb
	begin
		sum = '0;   // positive zero by default
		if (raw[24])
		begin
			// carry out, one right shift
			sum.sign = hi_op.sign;
			if (hi_op.exponent >= FLOAT_MAX_MAG.exponent)
			begin
				sum.exponent = FLOAT_MAX_MAG.exponent;
				sum.mantissa = FLOAT_MAX_MAG.mantissa;
			end
			else
			begin
				sum.exponent = hi_op.exponent + 8'd1;
				sum.mantissa = raw[23:1];
			end
		end
		else if ((raw[23:0] != 24'd0) && (norm_exp > 10'sd0))
		begin
			sum.sign     = hi_op.sign;
			sum.exponent = norm_exp[7:0];
			sum.mantissa = norm_mant[22:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/neuron_node.sv
`default_nettype none

module neuron_node import nn_pkg::*; #(
	parameter int node_index = 0   // row of node_weights
) (
	input logic clk,
	node_if.node nd
);

	float_t prod    [N_INPUTS];
	float_t lvl1    [N_INPUTS/2];
	float_t lvl2    [N_INPUTS/4];
	float_t raw_sum;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// weighted inputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < N_INPUTS; i++)
	begin : mult_gen
		float_mult mult_i (
			.x (nd.act[i]),
			.y (node_weights[node_index][i]),
			.z (prod[i])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// adder tree, pairwise
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 0+1, 2+3, 4+5, 6+7
	for (genvar i = 0; i < N_INPUTS/2; i++)
	begin : lvl1_gen
		float_adder add_i (
			.a   (prod[2*i]),
			.b   (prod[2*i+1]),
			.sum (lvl1[i])
		);
	end

	for (genvar i = 0; i < N_INPUTS/4; i++)
	begin : lvl2_gen
		float_adder add_i (
			.a   (lvl1[2*i]),
			.b   (lvl1[2*i+1]),
			.sum (lvl2[i])
		);
	end

	float_adder add_top (
		.a   (lvl2[0]),
		.b   (lvl2[1]),
		.sum (raw_sum)
	);

	// relu
	assign nd.sum     = raw_sum.sign ? '0 : raw_sum;
	assign nd.sum_neg = nd.act_valid & raw_sum.sign;   // only for a live vector

endmodule

`default_nettype wire

//--- logic/nn_layer.sv
`default_nettype none

module nn_layer import nn_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  act_vec_t in_act,
	output logic     out_valid,
	output float_t   out_result [N_NODES]
);

	slot_state_t        in_slot;
	slot_state_t        out_slot;
	act_vec_t           act_q;
	float_t             node_sum [N_NODES];
	logic [N_NODES-1:0] node_neg;   // watched by the bound checker

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// slot tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_slot  <= slot_empty;
			out_slot <= slot_empty;
		end
		else
		begin
			in_slot  <= in_valid ? slot_full : slot_empty;
			out_slot <= in_slot;   // one vector per slot, no stall
		end
	end

	// input register
	always_ff @(posedge clk)
	begin
		if (in_valid)
			act_q <= in_act;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// neurons
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar g = 0; g < N_NODES; g++)
	begin : node_gen
		node_if nb ();

		assign nb.act       = act_q;   // same vector to every neuron
		assign nb.act_valid = (in_slot == slot_full);
		assign node_sum[g]  = nb.sum;
		assign node_neg[g]  = nb.sum_neg;

		neuron_node #(
			.node_index (g)
		) node_i (
			.clk (clk),
			.nd  (nb)
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (rst)
			out_result <= '{default: '0};
		else if (in_slot == slot_full)
			out_result <= node_sum;
	end

	assign out_valid = (out_slot == slot_full);

endmodule

`default_nettype wire

//--- tb/nn_layer_assertions.sv
`default_nettype none

module nn_layer_assertions import nn_pkg::*; (
	input logic               clk,
	input logic               rst,
	input logic               in_valid,
	input logic               out_valid,
	input float_t             out_result [N_NODES],
	input slot_state_t        out_slot,
	input logic [N_NODES-1:0] node_neg
);

	int   fail_count = 0;
	logic any_neg;

	always_comb
	begin
		any_neg = 1'b0;
		for (int k = 0; k < N_NODES; k++)
			any_neg = any_neg | out_result[k].sign;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_quiet_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else
		begin
			fail_count++;
			$error("out_valid high in the cycle after reset");
		end

	// two register stages between strobe and result
	a_latency: assert property (@(posedge clk) disable iff (rst)
		!$past(rst, 1) && !$past(rst, 2) |-> out_valid == $past(in_valid, 2))
		else
		begin
			fail_count++;
			$error("out_valid does not follow in_valid by two cycles");
		end

	// slot pipeline, input slot then output slot
	a_slot_follows_strobe: assert property (@(posedge clk) disable iff (rst)
		!$past(rst, 1) && !$past(rst, 2) |-> (out_slot == slot_full) == $past(in_valid, 2))
		else
		begin
			fail_count++;
			$error("output slot state does not follow in_valid by two cycles");
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// relu
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_no_negative: assert property (@(posedge clk) disable iff (rst) !any_neg)
		else
		begin
			fail_count++;
			$error("a result has its sign bit set");
		end

	for (genvar g = 0; g < N_NODES; g++)
	begin : clamp_gen
		a_neg_clamped: assert property (@(posedge clk) disable iff (rst)
			node_neg[g] |=> out_result[g] == '0)
			else
			begin
				fail_count++;
				$error("negative sum of a neuron was not clamped to zero");
			end
	end

endmodule

bind nn_layer nn_layer_assertions chk_i (
	.clk        (clk),
	.rst        (rst),
	.in_valid   (in_valid),
	.out_valid  (out_valid),
	.out_result (out_result),
	.out_slot   (out_slot),
	.node_neg   (node_neg)
);

`default_nettype wire

//--- tb/nn_layer_tb.sv
`default_nettype none

module nn_layer_tb import nn_pkg::*; ();

	typedef float_t [N_NODES-1:0] result_t;

	localparam int RESET_CYCLES = 4;
	localparam int STIM_CYCLES  = 500;
	localparam int MAX_CYCLES   = RESET_CYCLES + STIM_CYCLES + 96;   // drain margin

	logic     clk;
	logic     rst;
	logic     in_valid;
	act_vec_t in_act;
	logic     out_valid;
	float_t   out_result [N_NODES];

	int      seed = 32'h7e8e_cf52;
	int      cycle_count = 0;
	int      errors = 0;
	int      accepted = 0;
	int      results = 0;
	result_t exp_q [$];
	int      issue_q [$];

	nn_layer nn_layer_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_act     (in_act),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic float_t model_mult(float_t a, float_t b);
		logic [47:0] p;
		int          e;
		float_t      r;
		r = '0;
		if (a.exponent == 8'd0 || b.exponent == 8'd0)
			return r;
		p = 48'({1'b1, a.mantissa}) * 48'({1'b1, b.mantissa});
		e = int'(a.exponent) + int'(b.exponent) - EXP_BIAS;
		if (p[47])
		begin
			p = p >> 1;
			e = e + 1;
		end
		if (e <= 0)
			return r;   // underflow
		r.sign = a.sign ^ b.sign;
		if (e > 254)
		begin
			r.exponent = 8'd254;
			r.mantissa = '1;
		end
		else
		begin
			r.exponent = 8'(e);
			r.mantissa = p[45:23];
		end
		return r;
	endfunction

	function automatic float_t model_add(float_t a, float_t b);
		float_t      big;
		float_t      smaller;
		float_t      r;
		logic [24:0] acc;
		logic [24:0] m_small;
		int          e;
		r = '0;
		if (a.exponent == 8'd0)
			a = '0;
		if (b.exponent == 8'd0)
			b = '0;
		big     = (a[30:0] >= b[30:0]) ? a : b;
		smaller = (a[30:0] >= b[30:0]) ? b : a;
		m_small = {1'b0, smaller.exponent != 8'd0, smaller.mantissa}
			>> (int'(big.exponent) - int'(smaller.exponent));
		acc = {1'b0, big.exponent != 8'd0, big.mantissa};
		acc = (big.sign != smaller.sign) ? acc - m_small : acc + m_small;
		e = int'(big.exponent);
		if (acc[24])
		begin
			r.sign     = big.sign;
			r.exponent = (e >= 254) ? 8'd254 : 8'(e + 1);
			r.mantissa = (e >= 254) ? '1 : acc[23:1];
		end
		else if (acc != 25'd0)
		begin
			while (!acc[23])
			begin
				acc = acc << 1;
				e   = e - 1;
			end
			if (e > 0)
			begin
				r.sign     = big.sign;
				r.exponent = 8'(e);
				r.mantissa = acc[22:0];
			end
		end
		return r;
	endfunction

	function automatic float_t model_node(act_vec_t v, int n);
		float_t p [N_INPUTS];
		float_t s;
		for (int i = 0; i < N_INPUTS; i++)
			p[i] = model_mult(v[i], node_weights[n][i]);
		s = model_add(model_add(model_add(p[0], p[1]), model_add(p[2], p[3])),
			model_add(model_add(p[4], p[5]), model_add(p[6], p[7])));
		return s.sign ? '0 : s;   // relu
	endfunction

	function automatic result_t model_layer(act_vec_t v);
		result_t r;
		for (int n = 0; n < N_NODES; n++)
			r[n] = model_node(v, n);
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic make_random_act(output act_vec_t v);
		logic [31:0] r;
		logic [31:0] c;
		for (int i = 0; i < N_INPUTS; i++)
		begin
			r = $random(seed);
			c = $random(seed);
			v[i].sign     = (c[5:4] == 2'b00);
			v[i].exponent = 8'd118 + c[15:8] % 8'd15;
			v[i].mantissa = r[22:0];
			if (c[2:0] == 3'd0)
			begin
				v[i].exponent = 8'd0;   // zero, mantissa sometimes left dirty
				v[i].mantissa = c[6] ? r[22:0] : 23'd0;
			end
		end
	endtask

	task automatic drive_vector(input logic valid, input act_vec_t v);
		in_valid = valid;
		in_act   = v;
		if (valid)
		begin
			exp_q.push_back(model_layer(v));
			issue_q.push_back(cycle_count);   // cycle of the strobe
			accepted++;
		end
	endtask

	task automatic check_outputs();
		result_t want;
		int      issue;
		if (!out_valid)
		begin
			for (int k = 0; k < N_NODES; k++)
				if (results == 0)
					assert (out_result[k] == '0)
					else
					begin
						$display("mismatch at %0t: out_result[%0d] expected %h got %h", $time, k,
							32'h0, out_result[k]);
						errors++;
					end
			return;
		end
		assert (exp_q.size() > 0)
		else
		begin
			$display("at %0t: out_valid high with no vector pending", $time);
			errors++;
		end
		if (exp_q.size() == 0)
			return;
		want  = exp_q.pop_front();
		issue = issue_q.pop_front();
		results++;
		assert (cycle_count - issue == 2)
		else
		begin
			$display("at %0t: vector from cycle %0d came out at cycle %0d", $time, issue,
				cycle_count);
			errors++;
		end
		for (int k = 0; k < N_NODES; k++)
			assert (out_result[k] == want[k])
			else
			begin
				$display("mismatch at %0t: out_result[%0d] expected %h got %h", $time, k,
					want[k], out_result[k]);
				errors++;
			end
	endtask

	initial
	begin
		act_vec_t v;
		logic     valid;
		logic [31:0] r;
		int       total;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_act   = '{default: '0};
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int c = 0; c < STIM_CYCLES; c++)
		begin
			@(negedge clk);
			check_outputs();
			v     = '{default: '0};
			valid = 1'b0;
			if (c == 3)
				valid = 1'b1;   // all-zero vector
			else if (c == 8 || (c >= 13 && c < 19))
			begin
				valid = 1'b1;   // isolated, then a burst
				make_random_act(v);
			end
			else if (c >= 20)
			begin
				r     = $random(seed);
				valid = (r % 10) < 7;
				make_random_act(v);
			end
			drive_vector(valid, v);
		end
		@(negedge clk);
		check_outputs();
		drive_vector(1'b0, '{default: '0});
		while (exp_q.size() != 0)
		begin
			@(negedge clk);
			check_outputs();
		end
		repeat (4)
		begin
			@(negedge clk);
			check_outputs();
		end
		assert (results == accepted)
		else
		begin
			$display("%0d vectors accepted but %0d results came out", accepted, results);
			errors++;
		end
		total = errors + nn_layer_i.chk_i.fail_count;
		$display("checks failed: %0d, assertions failed: %0d, results: %0d of %0d", errors,
			nn_layer_i.chk_i.fail_count, results, accepted);
		if (total == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial
	begin
		while (cycle_count < MAX_CYCLES)
			@(posedge clk);
		$display("timeout after %0d cycles, %0d vectors never came out", cycle_count,
			exp_q.size());
		errors++;
		$display("checks failed: %0d, assertions failed: %0d, results: %0d of %0d", errors,
			nn_layer_i.chk_i.fail_count, results, accepted);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- nn_layer.f
logic/nn_pkg.sv
logic/node_if.sv
logic/float_mult.sv
logic/float_adder.sv
logic/neuron_node.sv
logic/nn_layer.sv
tb/nn_layer_assertions.sv
tb/nn_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the nn_layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nn_layer_tb -f nn_layer.f \
	-o nn_layer_sim || { echo "build failed"; exit 1; }

./obj_dir/nn_layer_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: run ended without a verdict"; exit 1; }
echo "PASS"
